/* tests/clock_soc_vectors.txt */
// gpi stimulus and expected gpo, both hex
// low bytes fd to ff wrap, upper gpi byte has no effect
0012 00e5
ff00 00f3
a512 00e5
0000 00f3
00fd 00f0
3cfe 00f1
00ff 00f2
1280 0073
55aa 005d

/* clock_soc.f */
+incdir+source
source/soc_pkg.sv
source/cpu_decode.sv
source/cpu_execute.sv
source/cpu_result.sv
source/program_rom.sv
source/memory_map.sv
source/clock_soc.sv
tests/clock_soc_chk.sv
tests/clock_soc_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= clock_soc_tb
FILELIST  ?= clock_soc.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert --timescale 1ns/1ps
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= NO ERRORS

.PHONY: compile run clean

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	out=$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS)); echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* tests/clock_soc_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "soc_config.svh"

module clock_soc_tb;

    localparam int timeout_cycles = 200;
    localparam int random_count   = 8;

    logic        clk;
    logic        reset;
    logic [15:0] gpi;
    logic [15:0] gpo;

    int mismatches;
    int failures;
    int seed;

    clock_soc i_dut (
        .clk   (clk),
        .reset (reset),
        .gpi   (gpi),
        .gpo   (gpo)
    );

    always #10 clk = ~clk;

    // low byte plus constant wraps at 8 bits, upper output byte stays zero
    function automatic logic [15:0] expected_gpo(input logic [15:0] value);
        logic [7:0] sum;
        sum = value[7:0] + 8'(`SOC_ADD_CONST);
        return {8'h00, sum ^ `SOC_XOR_CONST};
    endfunction

    task automatic apply_gpi(input logic [15:0] value);
        @(posedge clk);
        gpi <= value;
    endtask

    // poll on the falling edge until gpo matches or the loop runs out
    task automatic wait_for_gpo(input string name, input logic [15:0] expected);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (gpo !== expected && cycles < timeout_cycles);
        if (gpo !== expected) begin
            $display("timeout: gpo did not settle within %0d cycles in %s", timeout_cycles, name);
            failures++;
            $display("mismatch %s expected %h actual %h", name, expected, gpo);
            mismatches++;
        end
    endtask

    task automatic run_file_vectors();
        int                fd;
        int                count;
        int                matched;
        logic              done;
        logic [15:0]       stim;
        logic [15:0]       expected;
        logic [8*100-1:0]  line;
        fd = $fopen("tests/clock_soc_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file tests/clock_soc_vectors.txt");
            failures++;
            return;
        end
        count = 0;
        done  = 1'b0;
        while (!done) begin
            line = '0;
            if ($fgets(line, fd) == 0) begin
                done = 1'b1;
            end else begin
                // comment and blank lines give no match
                matched = $sscanf(line, "%h %h", stim, expected);
                if (matched == 2) begin
                    apply_gpi(stim);
                    wait_for_gpo($sformatf("vector_%0d", count), expected);
                    count++;
                end
            end
        end
        $fclose(fd);
        if (count == 0) begin
            $display("no vectors were read from the vector file");
            failures++;
        end
    endtask

    // no reset between values, the program loop has to keep running
    task automatic run_random_values();
        int value;
        for (int i = 0; i < random_count; i++) begin
            value = $random(seed);
            apply_gpi(value[15:0]);
            wait_for_gpo($sformatf("random_%0d", i), expected_gpo(value[15:0]));
        end
    endtask

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        gpi        = '0;
        mismatches = 0;
        failures   = 0;
        seed       = 7;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        if (gpo !== 16'h0000) begin
            $display("mismatch reset expected %h actual %h", 16'h0000, gpo);
            mismatches++;
        end
        run_file_vectors();
        run_random_values();
        failures += i_dut.rules.violations;
        $display("mismatches %0d, other failures %0d", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/clock_soc_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module clock_soc_chk (
    input logic                clk,
    input logic                reset,
    input soc_pkg::cpu_state_t state,
    input soc_pkg::bus_req_t   bus_req
);
    import soc_pkg::*;

    int violations = 0;

    function automatic cpu_state_t following(input cpu_state_t s);
        case (s)
            st_fetch:   return st_decode;
            st_decode:  return st_execute;
            st_execute: return st_result;
            default:    return st_fetch;
        endcase
    endfunction

    // stores only land in ram or io
    write_region: assert property (@(posedge clk) disable iff (reset)
        bus_req.write_en |-> bus_req.addr[15])
    else begin
        violations++;
        $error("store to an address with bit 15 clear");
    end

    write_state: assert property (@(posedge clk) disable iff (reset)
        bus_req.write_en |-> state == st_execute)
    else begin
        violations++;
        $error("write enable outside the execute state");
    end

    // fixed four step cycle once out of reset
    state_order: assert property (@(posedge clk) disable iff (reset)
        !reset |=> state == following($past(state)))
    else begin
        violations++;
        $error("state left the fetch, decode, execute, result order");
    end

endmodule

bind clock_soc clock_soc_chk rules (
    .clk     (clk),
    .reset   (reset),
    .state   (state),
    .bus_req (bus_req)
);

`default_nettype wire

/* source/clock_soc.sv */
`timescale 1ns/1ps
`default_nettype none

module clock_soc (
    input  logic        clk,
    input  logic        reset,
    input  logic [15:0] gpi,
    output logic [15:0] gpo
);
    import soc_pkg::*;

    // cpu internals
    cpu_state_t     state;
    decoded_instr_t instr;
    exec_result_t   result;
    word_t          acc;
    word_t          pc;

    // shared bus
    bus_req_t       bus_req;
    word_t          rom_data;
    word_t          rdata;

    cpu_decode cpu_dec (
        .clk   (clk),
        .reset (reset),
        .rdata (rdata),
        .state (state),
        .instr (instr)
    );

    cpu_execute cpu_exe (
        .state   (state),
        .instr   (instr),
        .acc     (acc),
        .pc      (pc),
        .rdata   (rdata),
        .bus_req (bus_req),
        .result  (result)
    );

    cpu_result cpu_res (
        .clk    (clk),
        .reset  (reset),
        .state  (state),
        .result (result),
        .acc    (acc),
        .pc     (pc)
    );

    program_rom rom (
        .clk     (clk),
        .bus_req (bus_req),
        .rdata   (rom_data)
    );

    // ram, gpio and the read merge
    memory_map mem_map (
        .clk      (clk),
        .reset    (reset),
        .bus_req  (bus_req),
        .rom_data (rom_data),
        .gpi      (gpi),
        .gpo      (gpo),
        .rdata    (rdata)
    );

endmodule

`default_nettype wire

/* source/memory_map.sv */
`timescale 1ns/1ps
`default_nettype none

`include "soc_config.svh"

module memory_map (
    input  logic              clk,
    input  logic              reset,
    input  soc_pkg::bus_req_t bus_req,
    input  soc_pkg::word_t    rom_data,
    input  logic [15:0]       gpi,
    output logic [15:0]       gpo,
    output soc_pkg::word_t    rdata
);
    import soc_pkg::*;

    localparam int    ram_aw = $clog2(`SOC_RAM_WORDS);
    localparam byte_t in_lo  = byte_t'(`SOC_GPIO_IN_LO);
    localparam byte_t in_hi  = byte_t'(`SOC_GPIO_IN_LO + 1);
    localparam byte_t out_lo = byte_t'(`SOC_GPIO_OUT_LO);
    localparam byte_t out_hi = byte_t'(`SOC_GPIO_OUT_LO + 1);

    logic              ram_sel;
    logic              io_sel;
    logic [ram_aw-1:0] ram_idx;
    byte_t             io_off;
    byte_t             din_periph;
    byte_t             dout_periph;
    byte_t             periph_q;
    logic              periph_odd_q;
    word_t             periph_word;
    word_t             ram_q;
    word_t             ram [`SOC_RAM_WORDS];

    assign ram_sel = (bus_req.addr >= `SOC_RAM_BASE) && (bus_req.addr < `SOC_IO_BASE);
    assign io_sel  = (bus_req.addr >= `SOC_IO_BASE);
    assign ram_idx = bus_req.addr[ram_aw:1];
    assign io_off  = byte_t'(bus_req.addr - `SOC_IO_BASE);

    // odd peripheral addresses take the upper lane
    assign din_periph = bus_req.addr[0] ? bus_req.wdata[15:8] : bus_req.wdata[7:0];

    always_comb begin
        case (io_off)
            in_lo:   dout_periph = gpi[7:0];
            in_hi:   dout_periph = gpi[15:8];
            out_lo:  dout_periph = gpo[7:0];
            out_hi:  dout_periph = gpo[15:8];
            default: dout_periph = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            gpo <= '0;
        end else if (io_sel && bus_req.write_en) begin
            if (io_off == out_lo) begin
                gpo[7:0] <= din_periph;
            end
            if (io_off == out_hi) begin
                gpo[15:8] <= din_periph;
            end
        end
    end

    // registered responses, each zero when not selected
    always_ff @(posedge clk) begin
        if (ram_sel && bus_req.write_en) begin
            ram[ram_idx] <= bus_req.wdata;
        end
        ram_q        <= ram_sel ? ram[ram_idx] : '0;
        periph_q     <= io_sel ? dout_periph : '0;
        periph_odd_q <= bus_req.addr[0];
    end

    assign periph_word = periph_odd_q ? {periph_q, 8'h00} : {8'h00, periph_q};
    assign rdata       = rom_data | ram_q | periph_word;

endmodule

`default_nettype wire

/* source/program_rom.sv */
`timescale 1ns/1ps
`default_nettype none

`include "soc_config.svh"

module program_rom (
    input  logic              clk,
    input  soc_pkg::bus_req_t bus_req,
    output soc_pkg::word_t    rdata
);
    import soc_pkg::*;

    logic [13:0]    word_idx;
    decoded_instr_t rom_word;

    assign word_idx = bus_req.addr[14:1];

    // gpi low byte plus constant, through ram, xor, out to gpo
    always_comb begin
        case (word_idx)
            14'd0:   rom_word = '{op_ld_io, operand_t'(`SOC_GPIO_IN_LO)};
            14'd1:   rom_word = '{op_addi, operand_t'(`SOC_ADD_CONST)};
            14'd2:   rom_word = '{op_st_ram, operand_t'(0)};
            14'd3:   rom_word = '{op_ld_ram, operand_t'(0)};
            14'd4:   rom_word = '{op_xori, operand_t'(`SOC_XOR_CONST)};
            14'd5:   rom_word = '{op_st_io, operand_t'(`SOC_GPIO_OUT_LO)};
            14'd6:   rom_word = '{op_jmp, operand_t'(0)};
            default: rom_word = '{op_ldi, operand_t'(0)};
        endcase
    end

    // region is 0x0000 to 0x7fff, zero elsewhere for the read merge
    always_ff @(posedge clk) begin
        rdata <= bus_req.addr[15] ? '0 : word_t'(rom_word);
    end

endmodule

`default_nettype wire

/* source/cpu_result.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_result (
    input  logic                  clk,
    input  logic                  reset,
    input  soc_pkg::cpu_state_t   state,
    input  soc_pkg::exec_result_t result,
    output soc_pkg::word_t        acc,
    output soc_pkg::word_t        pc
);
    import soc_pkg::*;

    // instructions are one word, two bytes
    localparam word_t pc_step = word_t'(2);

    always_ff @(posedge clk) begin
        if (reset) begin
            acc <= '0;
            pc  <= '0;
        end else if (state == st_result) begin
            if (result.load_acc) begin
                acc <= result.value;
            end
            if (result.branch) begin
                pc <= result.target;
            end else begin
                pc <= pc + pc_step;
            end
        end
    end

endmodule

`default_nettype wire

/* source/cpu_execute.sv */
`timescale 1ns/1ps
`default_nettype none

`include "soc_config.svh"

module cpu_execute (
    input  soc_pkg::cpu_state_t     state,
    input  soc_pkg::decoded_instr_t instr,
    input  soc_pkg::word_t          acc,
    input  soc_pkg::word_t          pc,
    input  soc_pkg::word_t          rdata,
    output soc_pkg::bus_req_t       bus_req,
    output soc_pkg::exec_result_t   result
);
    import soc_pkg::*;

    word_t imm_ext;
    word_t ram_addr;
    word_t io_addr;
    word_t jmp_target;
    logic  is_store;

    assign imm_ext = word_t'(instr.operand);

    // ram operand is a word offset, io operand a byte offset
    assign ram_addr   = `SOC_RAM_BASE + word_t'({instr.operand, 1'b0});
    assign io_addr    = `SOC_IO_BASE + imm_ext;
    assign jmp_target = word_t'({instr.operand, 1'b0});
    assign is_store   = (instr.opcode == op_st_ram) || (instr.opcode == op_st_io);

    // pc on the bus except for the data access cycle
    always_comb begin
        bus_req.addr     = pc;
        bus_req.wdata    = acc;
        bus_req.write_en = 1'b0;
        if (state == st_execute) begin
            case (instr.opcode)
                op_ld_ram, op_st_ram: bus_req.addr = ram_addr;
                op_ld_io, op_st_io:   bus_req.addr = io_addr;
                default:              bus_req.addr = pc;
            endcase
            bus_req.write_en = is_store;
        end
    end

    // load data is only valid in st_result, which is when it is used
    always_comb begin
        result.value    = acc;
        result.load_acc = 1'b0;
        result.branch   = 1'b0;
        result.target   = jmp_target;
        case (instr.opcode)
            op_ldi: begin
                result.value    = imm_ext;
                result.load_acc = 1'b1;
            end
            op_addi: begin
                result.value    = acc + imm_ext;
                result.load_acc = 1'b1;
            end
            op_xori: begin
                result.value    = acc ^ imm_ext;
                result.load_acc = 1'b1;
            end
            op_ld_ram, op_ld_io: begin
                result.value    = rdata;
                result.load_acc = 1'b1;
            end
            op_jmp:  result.branch = 1'b1;
            default: result.load_acc = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* source/cpu_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_decode (
    input  logic                    clk,
    input  logic                    reset,
    input  soc_pkg::word_t          rdata,
    output soc_pkg::cpu_state_t     state,
    output soc_pkg::decoded_instr_t instr
);
    import soc_pkg::*;

    cpu_state_t next_state;
    opcode_t    fetched_opcode;
    operand_t   fetched_operand;

    // split the returned rom word into its fields
    assign fetched_opcode  = opcode_t'(rdata[$bits(word_t)-1 -: $bits(opcode_t)]);
    assign fetched_operand = rdata[$bits(operand_t)-1:0];

    // fixed four step sequence, no stalls
    always_comb begin
        case (state)
            st_fetch:   next_state = st_decode;
            st_decode:  next_state = st_execute;
            st_execute: next_state = st_result;
            default:    next_state = st_fetch;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= st_fetch;
            instr.opcode  <= op_ldi;
            instr.operand <= '0;
        end else begin
            state <= next_state;
            // rom word arrives one cycle after the fetch address
            if (state == st_decode) begin
                instr.opcode  <= fetched_opcode;
                instr.operand <= fetched_operand;
            end
        end
    end

endmodule

`default_nettype wire

/* source/soc_pkg.sv */
`default_nettype none

`include "soc_config.svh"

package soc_pkg;

    typedef logic [`SOC_WORD_W-1:0]    word_t;
    typedef logic [`SOC_BYTE_W-1:0]    byte_t;
    typedef logic [`SOC_OPERAND_W-1:0] operand_t;

    // opcodes in the upper nibble of each instruction word
    typedef enum logic [`SOC_OPCODE_W-1:0] {
        op_ldi,
        op_addi,
        op_xori,
        op_ld_ram,
        op_st_ram,
        op_ld_io,
        op_st_io,
        op_jmp
    } opcode_t;

    typedef struct packed {
        opcode_t  opcode;
        operand_t operand;
    } decoded_instr_t;

    typedef enum logic [1:0] {
        st_fetch,
        st_decode,
        st_execute,
        st_result
    } cpu_state_t;

    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  write_en;
    } bus_req_t;

    typedef struct packed {
        word_t value;
        logic  load_acc;
        logic  branch;
        word_t target;
    } exec_result_t;

endpackage

`default_nettype wire

/* source/soc_config.svh */
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// bus and instruction widths
`define SOC_WORD_W      16
`define SOC_BYTE_W      8
`define SOC_OPCODE_W    4
`define SOC_OPERAND_W   12

// memory map, rom below the ram base
`define SOC_RAM_BASE    16'h8000
`define SOC_IO_BASE     16'hFF00
`define SOC_RAM_WORDS   256

// gpio byte offsets from the io base
`define SOC_GPIO_IN_LO  0
`define SOC_GPIO_OUT_LO 2

// constants used by the fixed program
`define SOC_ADD_CONST   3
`define SOC_XOR_CONST   8'hF0

`endif
